// File: all.f
+incdir+include
src/ppu_pkg.sv
src/ppu_vram_if.sv
src/ppu_regs.sv
src/ppu_vram_port.sv
src/ppu_timing.sv
src/ppu_top.sv
verif/tb_ppu_top.sv

// File: Bender.yml
package:
  name: ppu_cpu_side

export_include_dirs:
  - include

sources:
  - files:
      - src/ppu_pkg.sv
      - src/ppu_vram_if.sv
      - src/ppu_regs.sv
      - src/ppu_vram_port.sv
      - src/ppu_timing.sv
      - src/ppu_top.sv
  - target: simulation
    files:
      - verif/tb_ppu_top.sv

// File: verif/tb_ppu_top.sv
`timescale 1ns/1ns
`include "ppu_params.svh"

module tb_ppu_top;

	import ppu_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int FRAME_CYCLES = `PPU_CYCLES_PER_LINE * `PPU_LINES_PER_FRAME;
	// Edges from reset release until vblank sets
	localparam int VBLANK_EDGES = `PPU_VBLANK_LINE * `PPU_CYCLES_PER_LINE + 1;
	// Three frames plus margin, about 1.2 ms
	localparam longint WATCHDOG_NS = 3 * FRAME_CYCLES * CLK_PERIOD + 128000;
	localparam int MEM_DEPTH = 1 << `PPU_VADDR_W;

	logic       CLK = 1'b0;
	logic       RESET = 1'b1;
	ppu_data_t  cpu_wdata = '0;
	ppu_reg_e   cpu_addr = CTRL;
	logic       cpu_wren = 1'b0;
	logic       cpu_rden = 1'b0;
	ppu_data_t  cpu_rdata;
	logic       nmi_n;
	ppu_data_t  ppu_rdata = '0;
	ppu_data_t  ppu_wdata;
	ppu_vaddr_t ppu_addr;
	logic       ppu_write;
	logic       ppu_read;

	// External PPU memory
	ppu_data_t  mem [MEM_DEPTH];
	// Bus strobes the DUT still owes
	ppu_vaddr_t exp_wr_addr[$];
	ppu_data_t  exp_wr_data[$];
	ppu_vaddr_t exp_rd_addr[$];
	// Reference state
	ppu_vaddr_t cur_addr;
	logic       inc_down_model;
	ppu_data_t  buf_model;
	ppu_data_t  rdata_model;
	int         cyc_cnt;

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	ppu_top u_dut (
		.CLK       (CLK),
		.RESET     (RESET),
		.cpu_wdata (cpu_wdata),
		.cpu_addr  (cpu_addr),
		.cpu_wren  (cpu_wren),
		.cpu_rden  (cpu_rden),
		.cpu_rdata (cpu_rdata),
		.nmi_n     (nmi_n),
		.ppu_rdata (ppu_rdata),
		.ppu_wdata (ppu_wdata),
		.ppu_addr  (ppu_addr),
		.ppu_write (ppu_write),
		.ppu_read  (ppu_read)
	);

	// Edges since reset release
	always @(posedge CLK) begin
		if (RESET) begin
			cyc_cnt <= 0;
		end else begin
			cyc_cnt <= cyc_cnt + 1;
		end
	end

	// Memory answers a read one cycle after ppu_read
	always @(posedge CLK) begin
		if (ppu_write) begin
			mem[ppu_addr] <= ppu_wdata;
		end
		if (ppu_read) begin
			ppu_rdata <= mem[ppu_addr];
		end
	end

	// ========================================================================
	// Error reporting and compare tasks
	// ========================================================================

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic check_data(string name, ppu_data_t got, ppu_data_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_addr(string name, ppu_vaddr_t got, ppu_vaddr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// ========================================================================
	// Reference functions
	// ========================================================================

	// Fill byte mixes every address bit
	function automatic ppu_data_t fill_byte(ppu_vaddr_t a);
		return a[7:0] ^ {a[13:8], 2'b11};
	endfunction

	// Step after PPUDATA, bus address wraps at 14 bits
	function automatic ppu_vaddr_t next_addr(ppu_vaddr_t a, logic down);
		if (down) begin
			return a + ppu_vaddr_t'(`PPU_INC_DOWN);
		end
		return a + ppu_vaddr_t'(`PPU_INC_ACROSS);
	endfunction

	// High byte keeps 6 bits, bit 14 cleared and never on the bus
	function automatic ppu_vaddr_t addr_from_bytes(ppu_data_t hi, ppu_data_t lo);
		return {hi[5:0], lo};
	endfunction

	// Vblank on top, sprite flags 0, low bits from the last read
	function automatic ppu_data_t status_byte(logic vbl, ppu_data_t prev);
		return {vbl, 2'b00, prev[4:0]};
	endfunction

	// Compares every bus strobe with the owed access
	always @(negedge CLK) begin
		if (!RESET && ppu_write) begin
			if (exp_wr_addr.size() == 0) begin
				stop_on_error("ppu_write pulsed with no PPUDATA write pending");
			end else begin
				check_addr("ppu_addr", ppu_addr, exp_wr_addr.pop_front());
				check_data("ppu_wdata", ppu_wdata, exp_wr_data.pop_front());
			end
		end
		if (!RESET && ppu_read) begin
			if (exp_rd_addr.size() == 0) begin
				stop_on_error("ppu_read pulsed with no PPUDATA read pending");
			end else begin
				check_addr("ppu_addr", ppu_addr, exp_rd_addr.pop_front());
			end
		end
	end

	// ========================================================================
	// CPU side stimulus
	// ========================================================================

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic idle(int n);
		repeat (n) step();
	endtask

	task automatic reg_write(ppu_reg_e r, ppu_data_t d);
		cpu_addr  = r;
		cpu_wdata = d;
		cpu_wren  = 1'b1;
		step();
		cpu_wren  = 1'b0;
	endtask

	// Result is valid right after the sampling edge
	task automatic reg_read(ppu_reg_e r, output ppu_data_t d);
		cpu_addr = r;
		cpu_rden = 1'b1;
		step();
		cpu_rden = 1'b0;
		d = cpu_rdata;
	endtask

	task automatic set_ctrl(ppu_data_t d);
		reg_write(CTRL, d);
		inc_down_model = d[2];
	endtask

	task automatic set_addr(ppu_data_t hi, ppu_data_t lo);
		reg_write(ADDR, hi);
		reg_write(ADDR, lo);
		cur_addr = addr_from_bytes(hi, lo);
	endtask

	task automatic data_write(ppu_data_t d);
		exp_wr_addr.push_back(cur_addr);
		exp_wr_data.push_back(d);
		reg_write(DATA, d);
		// Strobe follows one edge after the CPU write
		check_flag("ppu_write", ppu_write, 1'b1);
		cur_addr = next_addr(cur_addr, inc_down_model);
		// CPU gap between PPUDATA accesses
		idle(3);
	endtask

	// Returns the old buffer, then the buffer takes this address
	task automatic data_read();
		ppu_data_t got;
		exp_rd_addr.push_back(cur_addr);
		reg_read(DATA, got);
		check_data("cpu_rdata", got, buf_model);
		// Strobe follows one edge after the CPU read
		check_flag("ppu_read", ppu_read, 1'b1);
		rdata_model = buf_model;
		buf_model   = mem[cur_addr];
		cur_addr    = next_addr(cur_addr, inc_down_model);
		idle(3);
	endtask

	task automatic status_read(logic vbl);
		ppu_data_t got;
		reg_read(STATUS, got);
		check_data("cpu_rdata", got, status_byte(vbl, rdata_model));
		rdata_model = status_byte(vbl, rdata_model);
	endtask

	task automatic wait_bus_drained();
		for (int i = 0; i < 8; i++) begin
			if (exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0) begin
				step();
			end
		end
		if (exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0) begin
			stop_on_error("a queued PPUDATA access never reached the PPU bus");
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		ppu_data_t   hi;
		ppu_data_t   lo;
		ppu_data_t   got;
		int unsigned seed_val;
		seed_val = $urandom(32'h7abc);
		for (int i = 0; i < MEM_DEPTH; i++) begin
			mem[i] = fill_byte(ppu_vaddr_t'(i));
		end
		cur_addr       = '0;
		inc_down_model = 1'b0;
		buf_model      = '0;
		rdata_model    = '0;
		idle(16);
		RESET = 1'b0;

		// Idle bus after reset, write-only registers read 0
		repeat (8) begin
			step();
			check_flag("nmi_n", nmi_n, 1'b1);
			check_flag("ppu_read", ppu_read, 1'b0);
			check_flag("ppu_write", ppu_write, 1'b0);
		end
		reg_read(CTRL, got);
		check_data("cpu_rdata", got, 8'h00);
		reg_read(MASK, got);
		check_data("cpu_rdata", got, 8'h00);

		// Writes stepping across
		hi = ppu_data_t'($urandom());
		lo = ppu_data_t'($urandom());
		set_addr(hi, lo);
		repeat (8) data_write(ppu_data_t'($urandom()));
		wait_bus_drained();
		// Writes stepping down, near the top so the address wraps
		set_ctrl(8'h04);
		set_addr(8'h3f, ppu_data_t'($urandom()) | 8'hc0);
		repeat (6) data_write(ppu_data_t'($urandom()));
		wait_bus_drained();

		// Buffered reads, first one is stale
		set_ctrl(8'h00);
		set_addr(ppu_data_t'($urandom()), ppu_data_t'($urandom()));
		repeat (3) data_read();
		// Write-only registers still read 0 after a data byte
		reg_read(CTRL, got);
		check_data("cpu_rdata", got, 8'h00);
		reg_read(MASK, got);
		check_data("cpu_rdata", got, 8'h00);
		rdata_model = 8'h00;
		repeat (3) data_read();
		wait_bus_drained();

		// Status read clears the latch left set by one scroll write
		reg_write(SCROLL, ppu_data_t'($urandom()));
		status_read(1'b0);
		set_addr(ppu_data_t'($urandom()), ppu_data_t'($urandom()));
		data_write(ppu_data_t'($urandom()));
		wait_bus_drained();

		// NMI at the start of vblank
		set_ctrl(8'h80);
		while (nmi_n !== 1'b0) begin
			if (cyc_cnt > VBLANK_EDGES + 2) begin
				stop_on_error($sformatf("nmi_n still high %0d cycles after reset", cyc_cnt));
			end else begin
				step();
			end
		end
		if (cyc_cnt < VBLANK_EDGES - 2) begin
			stop_on_error($sformatf("nmi_n fell early, %0d cycles after reset", cyc_cnt));
		end
		status_read(1'b1);
		for (int i = 0; i < 4 && nmi_n !== 1'b1; i++) begin
			step();
		end
		check_flag("nmi_n", nmi_n, 1'b1);
		status_read(1'b0);
		wait_bus_drained();

		$display("sim passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: src/ppu_top.sv
`timescale 1ns/1ns

module ppu_top (
	input  logic               CLK,
	input  logic               RESET,
	// CPU register window
	input  ppu_pkg::ppu_data_t  cpu_wdata,
	input  ppu_pkg::ppu_reg_e   cpu_addr,
	input  logic               cpu_wren,
	input  logic               cpu_rden,
	output ppu_pkg::ppu_data_t  cpu_rdata,
	output logic               nmi_n,
	// External PPU bus
	input  ppu_pkg::ppu_data_t  ppu_rdata,
	output ppu_pkg::ppu_data_t  ppu_wdata,
	output ppu_pkg::ppu_vaddr_t ppu_addr,
	output logic               ppu_write,
	output logic               ppu_read
);

	// Between the register block and frame timing
	logic vblank;
	logic nmi_en;
	logic status_rd;

	// PPUDATA request path
	ppu_vram_if vram_bus ();

	ppu_regs u_regs (
		.CLK       (CLK),
		.RESET     (RESET),
		.cpu_wdata (cpu_wdata),
		.cpu_addr  (cpu_addr),
		.cpu_wren  (cpu_wren),
		.cpu_rden  (cpu_rden),
		.cpu_rdata (cpu_rdata),
		.vblank    (vblank),
		.nmi_en    (nmi_en),
		.status_rd (status_rd),
		.vram      (vram_bus.regs)
	);

	ppu_vram_port u_port (
		.CLK       (CLK),
		.RESET     (RESET),
		.ppu_rdata (ppu_rdata),
		.ppu_wdata (ppu_wdata),
		.ppu_addr  (ppu_addr),
		.ppu_write (ppu_write),
		.ppu_read  (ppu_read),
		.vram      (vram_bus.port)
	);

	ppu_timing u_timing (
		.CLK       (CLK),
		.RESET     (RESET),
		.nmi_en    (nmi_en),
		.status_rd (status_rd),
		.vblank    (vblank),
		.nmi_n     (nmi_n)
	);

endmodule

// File: src/ppu_timing.sv
`timescale 1ns/1ns
`include "ppu_params.svh"

module ppu_timing (
	input  logic CLK,
	input  logic RESET,
	input  logic nmi_en,
	input  logic status_rd,
	output logic vblank,
	output logic nmi_n
);

	// Counter widths follow the frame geometry
	localparam int CYC_W  = $clog2(`PPU_CYCLES_PER_LINE);
	localparam int LINE_W = $clog2(`PPU_LINES_PER_FRAME);

	// Dot within the line
	logic [CYC_W-1:0]  cycle_cnt;
	// Scanline within the frame
	logic [LINE_W-1:0] line_cnt;
	logic              line_end;
	logic              frame_end;
	logic              vbl_set;
	logic              vbl_clr;

	// =======================================================================
	// Scanline and dot counters
	// =======================================================================

	assign line_end  = (cycle_cnt == CYC_W'(`PPU_CYCLES_PER_LINE - 1));
	assign frame_end = (line_cnt == LINE_W'(`PPU_LINES_PER_FRAME - 1));

	always_ff @(posedge CLK) begin
		if (RESET) begin
			cycle_cnt <= '0;
			line_cnt  <= '0;
		end else if (line_end) begin
			cycle_cnt <= '0;
			// Wrap to line 0 after the pre-render line
			if (frame_end) begin
				line_cnt <= '0;
			end else begin
				line_cnt <= line_cnt + 1'b1;
			end
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	// =======================================================================
	// Vblank flag and NMI
	// =======================================================================

	// Both events sit on dot 1 of their line
	assign vbl_set = (line_cnt == LINE_W'(`PPU_VBLANK_LINE)) && (cycle_cnt == CYC_W'(1));
	assign vbl_clr = (line_cnt == LINE_W'(`PPU_PRERENDER_LINE)) && (cycle_cnt == CYC_W'(1));

	always_ff @(posedge CLK) begin
		if (RESET) begin
			vblank <= 1'b0;
		end else if (vbl_clr || status_rd) begin
			// A status read in the set cycle swallows the flag
			vblank <= 1'b0;
		end else if (vbl_set) begin
			vblank <= 1'b1;
		end
	end

	// Active low, follows the enable right away
	assign nmi_n = ~(nmi_en & vblank);

	a_cnt_range: assert property (@(posedge CLK) disable iff (RESET)
		(cycle_cnt < CYC_W'(`PPU_CYCLES_PER_LINE))
		&& (line_cnt < LINE_W'(`PPU_LINES_PER_FRAME)));

endmodule

// File: src/ppu_vram_port.sv
`timescale 1ns/1ns

module ppu_vram_port (
	input  logic               CLK,
	input  logic               RESET,
	// External PPU bus
	input  ppu_pkg::ppu_data_t  ppu_rdata,
	output ppu_pkg::ppu_data_t  ppu_wdata,
	output ppu_pkg::ppu_vaddr_t ppu_addr,
	output logic               ppu_write,
	output logic               ppu_read,
	// Requests from the register block
	ppu_vram_if.port           vram
);

	import ppu_pkg::*;

	// Read in flight, memory answers the cycle after ppu_read
	logic      rd_pend;
	ppu_data_t rd_buf;

	assign vram.rbuf = rd_buf;

	// =======================================================================
	// Bus strobes and read buffer
	// =======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			ppu_write <= 1'b0;
			ppu_read  <= 1'b0;
			rd_pend   <= 1'b0;
			rd_buf    <= '0;
		end else begin
			// Each request becomes exactly one strobe cycle
			ppu_write <= vram.wr_req;
			ppu_read  <= vram.rd_req;
			rd_pend   <= ppu_read;
			if (rd_pend) begin
				rd_buf <= ppu_rdata;
			end
		end
	end

	// Address and data only move with a request
	always_ff @(posedge CLK) begin
		if (vram.wr_req || vram.rd_req) begin
			ppu_addr <= vram.addr;
		end
		if (vram.wr_req) begin
			ppu_wdata <= vram.wdata;
		end
	end

	// Exclusive CPU strobes keep the bus strobes apart
	a_bus_excl: assert property (@(posedge CLK) disable iff (RESET)
		!(ppu_read && ppu_write));

endmodule

// File: src/ppu_regs.sv
`timescale 1ns/1ns
`include "ppu_params.svh"

module ppu_regs (
	input  logic              CLK,
	input  logic              RESET,
	// CPU side
	input  ppu_pkg::ppu_data_t cpu_wdata,
	input  ppu_pkg::ppu_reg_e  cpu_addr,
	input  logic              cpu_wren,
	input  logic              cpu_rden,
	output ppu_pkg::ppu_data_t cpu_rdata,
	// Frame timing side
	input  logic              vblank,
	output logic              nmi_en,
	output logic              status_rd,
	// PPUDATA requests toward the bus port
	ppu_vram_if.regs          vram
);

	import ppu_pkg::*;

	// Shared write-twice toggle for SCROLL and ADDR
	logic       w_latch;
	// PPUCTRL bit 2, step by 32 when set
	logic       inc_down;
	// Temporary address filled by CTRL, SCROLL and ADDR
	ppu_taddr_t t_addr;
	// Current address used by PPUDATA
	ppu_taddr_t v_addr;
	// Step applied after every PPUDATA access
	ppu_taddr_t v_step;
	logic       data_wr;
	logic       data_rd;

	// =======================================================================
	// PPUDATA requests
	// =======================================================================

	assign data_wr = cpu_wren && (cpu_addr == DATA);
	assign data_rd = cpu_rden && (cpu_addr == DATA);

	// Requests go out in the same cycle as the CPU strobe
	// The port registers them into bus strobes
	assign vram.wr_req = data_wr;
	assign vram.rd_req = data_rd;
	assign vram.addr   = v_addr[`PPU_VADDR_W-1:0];
	assign vram.wdata  = cpu_wdata;

	// Wraps at 15 bits on its own
	assign v_step = inc_down ? ppu_taddr_t'(`PPU_INC_DOWN) : ppu_taddr_t'(`PPU_INC_ACROSS);

	// =======================================================================
	// CPU writes
	// =======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			w_latch  <= 1'b0;
			nmi_en   <= 1'b0;
			inc_down <= 1'b0;
			t_addr   <= '0;
			v_addr   <= '0;
		end else if (cpu_wren) begin
			case (cpu_addr)
				CTRL: begin
					nmi_en        <= cpu_wdata[7];
					inc_down      <= cpu_wdata[2];
					// Base nametable select
					t_addr[11:10] <= cpu_wdata[1:0];
				end
				SCROLL: begin
					w_latch <= ~w_latch;
					if (!w_latch) begin
						// Coarse X, fine X is not kept
						t_addr[4:0] <= cpu_wdata[7:3];
					end else begin
						// Coarse Y then fine Y
						t_addr[9:5]   <= cpu_wdata[7:3];
						t_addr[14:12] <= cpu_wdata[2:0];
					end
				end
				ADDR: begin
					w_latch <= ~w_latch;
					if (!w_latch) begin
						// High byte first, bit 14 forced low
						t_addr[13:8] <= cpu_wdata[5:0];
						t_addr[14]   <= 1'b0;
					end else begin
						// Low byte, then the whole address goes live
						t_addr[7:0] <= cpu_wdata;
						v_addr      <= {t_addr[14:8], cpu_wdata};
					end
				end
				DATA: begin
					v_addr <= v_addr + v_step;
				end
				// MASK, STATUS and OAM writes are ignored
				default: begin
				end
			endcase
		end else if (cpu_rden) begin
			if (cpu_addr == STATUS) begin
				w_latch <= 1'b0;
			end
			if (cpu_addr == DATA) begin
				v_addr <= v_addr + v_step;
			end
		end
	end

	// =======================================================================
	// CPU reads
	// =======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			cpu_rdata <= '0;
			status_rd <= 1'b0;
		end else begin
			// Timing block clears vblank one edge later
			status_rd <= cpu_rden && (cpu_addr == STATUS);
			if (cpu_rden) begin
				case (cpu_addr)
					CTRL, MASK: cpu_rdata <= '0;
					// Sprite flags read as 0, low bits keep the open bus value
					STATUS: cpu_rdata <= {vblank, 2'b00, cpu_rdata[4:0]};
					// Buffered read, the fresh byte lands in rbuf later
					DATA: cpu_rdata <= vram.rbuf;
					default: begin
					end
				endcase
			end
		end
	end

	// CPU never reads and writes in one cycle
	a_cpu_excl: assert property (@(posedge CLK) disable iff (RESET)
		!(cpu_wren && cpu_rden));

endmodule

// File: src/ppu_vram_if.sv
`timescale 1ns/1ns

// ===========================================================================
// Request path from the register block to the PPU bus port
// ===========================================================================

interface ppu_vram_if;

	import ppu_pkg::*;

	// One-cycle PPUDATA write request
	logic       wr_req;
	// One-cycle PPUDATA read request
	logic       rd_req;
	// Current address before the post-access step
	ppu_vaddr_t addr;
	// Byte the CPU wrote to PPUDATA
	ppu_data_t  wdata;
	// Read buffer, returned on the next PPUDATA read
	ppu_data_t  rbuf;

	// Register side issues requests and sees the buffer
	modport regs (
		output wr_req, rd_req, addr, wdata,
		input  rbuf
	);

	// Bus side turns requests into strobes and owns the buffer
	modport port (
		input  wr_req, rd_req, addr, wdata,
		output rbuf
	);

endinterface

// File: src/ppu_pkg.sv
`include "ppu_params.svh"

// ===========================================================================
// Shared PPU types
// ===========================================================================

package ppu_pkg;

	// One byte on either bus
	typedef logic [`PPU_DATA_W-1:0] ppu_data_t;

	// Address as it leaves the chip on the PPU bus
	typedef logic [`PPU_VADDR_W-1:0] ppu_vaddr_t;

	// Loopy style temporary and current address
	// Bit 14 only matters for scroll, the bus sees bits 13:0
	typedef logic [`PPU_TADDR_W-1:0] ppu_taddr_t;

	// CPU register index, mirrored every 8 bytes over $2000-$3FFF
	typedef enum logic [`PPU_REG_ADDR_W-1:0] {
		// Write only
		CTRL    = 3'd0,
		MASK    = 3'd1,
		// Read only
		STATUS  = 3'd2,
		// OAM pair, not kept in this design
		OAMADDR = 3'd3,
		OAMDATA = 3'd4,
		// Write twice, sharing one latch
		SCROLL  = 3'd5,
		ADDR    = 3'd6,
		// Read and write through the PPU bus
		DATA    = 3'd7
	} ppu_reg_e;

endpackage

// File: include/ppu_params.svh
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// ===========================================================================
// PPU widths and frame geometry
// ===========================================================================

// CPU and PPU bus byte width
`define PPU_DATA_W 8
// Register index into the mirrored $2000 window
`define PPU_REG_ADDR_W 3
// External PPU bus address width
`define PPU_VADDR_W 14
// Internal temporary and current VRAM address width
`define PPU_TADDR_W 15

// Dots per scanline and scanlines per frame
`define PPU_CYCLES_PER_LINE 341
`define PPU_LINES_PER_FRAME 262

// First vblank line and the pre-render line that ends vblank
`define PPU_VBLANK_LINE 241
`define PPU_PRERENDER_LINE 261

// VRAM address step after a PPUDATA access
// Across a row when PPUCTRL bit 2 is clear, down a column when set
`define PPU_INC_ACROSS 1
`define PPU_INC_DOWN 32

`endif
